//--- hdl/meta_merge.sv
/*
 * Metadata merge stage
 * Attaches queued items to frame starts and drives the TX register
 */

module meta_merge (
    input  logic                                                      clk,
    input  logic                                                      rst_n,

    input  logic [mfb_pkg::MFB_REGIONS*mfb_pkg::MFB_REGION_WIDTH-1:0] scan_data,
    input  logic [mfb_pkg::MFB_REGIONS*mfb_pkg::MFB_META_WIDTH-1:0]   scan_meta,
    input  logic [mfb_pkg::MFB_REGIONS-1:0]                           scan_sof,
    input  logic [mfb_pkg::MFB_REGIONS-1:0]                           scan_eof,
    input  logic [1:0]                                                scan_sof_cnt,
    input  logic [mfb_pkg::MFB_REGIONS-1:0]                           scan_item_idx,
    input  logic                                                      scan_vld,
    output logic                                                      scan_take,

    input  logic [mvb_pkg::MVB_ITEM_WIDTH-1:0]                        item_head0,
    input  logic [mvb_pkg::MVB_ITEM_WIDTH-1:0]                        item_head1,
    input  logic [mvb_pkg::MVB_CNT_WIDTH-1:0]                         item_cnt,
    output logic [1:0]                                                pop_cnt,

    output logic [mfb_pkg::MFB_REGIONS*mfb_pkg::MFB_REGION_WIDTH-1:0] tx_mfb_data,
    output mfb_pkg::meta_slot_u [mfb_pkg::MFB_REGIONS-1:0]            tx_mfb_slot,
    output logic [mfb_pkg::MFB_REGIONS-1:0]                           tx_mfb_sof,
    output logic [mfb_pkg::MFB_REGIONS-1:0]                           tx_mfb_eof,
    output logic                                                      tx_mfb_src_rdy,
    input  logic                                                      tx_mfb_dst_rdy
);
    import mvb_pkg::*;
    import mfb_pkg::*;

    logic                         out_free;
    logic                         items_ok;
    meta_slot_u [MFB_REGIONS-1:0] slot_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Take decision
    assign out_free  = !tx_mfb_src_rdy || tx_mfb_dst_rdy;  // Empty or being emptied
    assign items_ok  = item_cnt >= MVB_CNT_WIDTH'(scan_sof_cnt);
    assign scan_take = scan_vld && items_ok && out_free;
    assign pop_cnt   = scan_take ? scan_sof_cnt : 2'd0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Slot build
    always_comb begin
        for (int r = 0; r < MFB_REGIONS; r++) begin
            slot_next[r].fields.meta = scan_meta[r*MFB_META_WIDTH +: MFB_META_WIDTH];
            if (!scan_sof[r]) begin
                slot_next[r].fields.item = '0;  // No frame start here
            end else if (scan_item_idx[r]) begin
                slot_next[r].fields.item = item_head1;
            end else begin
                slot_next[r].fields.item = item_head0;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_mfb_src_rdy <= 1'b0;
        end else if (scan_take) begin
            tx_mfb_src_rdy <= 1'b1;
        end else if (tx_mfb_dst_rdy) begin
            tx_mfb_src_rdy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (scan_take) begin
            tx_mfb_data <= scan_data;
            tx_mfb_slot <= slot_next;
            tx_mfb_sof  <= scan_sof;
            tx_mfb_eof  <= scan_eof;
        end
    end

    // Held word must not move under back-pressure
    a_tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
        tx_mfb_src_rdy && !tx_mfb_dst_rdy |=> tx_mfb_src_rdy && $stable(tx_mfb_data)
            && $stable(tx_mfb_slot) && $stable(tx_mfb_sof) && $stable(tx_mfb_eof)
    ) else $error("TX word changed while stalled");

endmodule

//--- hdl/metadata_insertor.sv
/*
 * Frame metadata insertor
 * Places the oldest MVB item beside each MFB frame start
 */

module metadata_insertor (
    input  logic                                                      clk,
    input  logic                                                      rst_n,

    input  logic [mvb_pkg::MVB_ITEMS*mvb_pkg::MVB_ITEM_WIDTH-1:0]     rx_mvb_data,
    input  logic [mvb_pkg::MVB_ITEMS-1:0]                             rx_mvb_vld,
    input  logic                                                      rx_mvb_src_rdy,
    output logic                                                      rx_mvb_dst_rdy,

    input  logic [mfb_pkg::MFB_REGIONS*mfb_pkg::MFB_REGION_WIDTH-1:0] rx_mfb_data,
    input  logic [mfb_pkg::MFB_REGIONS*mfb_pkg::MFB_META_WIDTH-1:0]   rx_mfb_meta,
    input  logic [mfb_pkg::MFB_REGIONS-1:0]                           rx_mfb_sof,
    input  logic [mfb_pkg::MFB_REGIONS-1:0]                           rx_mfb_eof,
    input  logic                                                      rx_mfb_src_rdy,
    output logic                                                      rx_mfb_dst_rdy,

    output logic [mfb_pkg::MFB_REGIONS*mfb_pkg::MFB_REGION_WIDTH-1:0] tx_mfb_data,
    output logic [mfb_pkg::MFB_REGIONS*mfb_pkg::MFB_SLOT_WIDTH-1:0]   tx_mfb_meta,
    output logic [mfb_pkg::MFB_REGIONS-1:0]                           tx_mfb_sof,
    output logic [mfb_pkg::MFB_REGIONS-1:0]                           tx_mfb_eof,
    output logic                                                      tx_mfb_src_rdy,
    input  logic                                                      tx_mfb_dst_rdy
);
    import mvb_pkg::*;
    import mfb_pkg::*;

    logic [MVB_ITEM_WIDTH-1:0]                  item_head0;
    logic [MVB_ITEM_WIDTH-1:0]                  item_head1;
    logic [MVB_CNT_WIDTH-1:0]                   item_cnt;
    logic [1:0]                                 pop_cnt;

    logic [MFB_REGIONS*MFB_REGION_WIDTH-1:0]    scan_data;
    logic [MFB_REGIONS*MFB_META_WIDTH-1:0]      scan_meta;
    logic [MFB_REGIONS-1:0]                     scan_sof;
    logic [MFB_REGIONS-1:0]                     scan_eof;
    logic [1:0]                                 scan_sof_cnt;
    logic [MFB_REGIONS-1:0]                     scan_item_idx;
    logic                                       scan_vld;
    logic                                       scan_take;

    meta_slot_u [MFB_REGIONS-1:0]               tx_slot;

    mvb_item_queue queue_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .rx_mvb_data    (rx_mvb_data),
        .rx_mvb_vld     (rx_mvb_vld),
        .rx_mvb_src_rdy (rx_mvb_src_rdy),
        .rx_mvb_dst_rdy (rx_mvb_dst_rdy),
        .item_head0     (item_head0),
        .item_head1     (item_head1),
        .item_cnt       (item_cnt),
        .pop_cnt        (pop_cnt)
    );

    mfb_sof_scan scan_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .rx_mfb_data    (rx_mfb_data),
        .rx_mfb_meta    (rx_mfb_meta),
        .rx_mfb_sof     (rx_mfb_sof),
        .rx_mfb_eof     (rx_mfb_eof),
        .rx_mfb_src_rdy (rx_mfb_src_rdy),
        .rx_mfb_dst_rdy (rx_mfb_dst_rdy),
        .scan_data      (scan_data),
        .scan_meta      (scan_meta),
        .scan_sof       (scan_sof),
        .scan_eof       (scan_eof),
        .scan_sof_cnt   (scan_sof_cnt),
        .scan_item_idx  (scan_item_idx),
        .scan_vld       (scan_vld),
        .scan_take      (scan_take)
    );

    meta_merge merge_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .scan_data      (scan_data),
        .scan_meta      (scan_meta),
        .scan_sof       (scan_sof),
        .scan_eof       (scan_eof),
        .scan_sof_cnt   (scan_sof_cnt),
        .scan_item_idx  (scan_item_idx),
        .scan_vld       (scan_vld),
        .scan_take      (scan_take),
        .item_head0     (item_head0),
        .item_head1     (item_head1),
        .item_cnt       (item_cnt),
        .pop_cnt        (pop_cnt),
        .tx_mfb_data    (tx_mfb_data),
        .tx_mfb_slot    (tx_slot),
        .tx_mfb_sof     (tx_mfb_sof),
        .tx_mfb_eof     (tx_mfb_eof),
        .tx_mfb_src_rdy (tx_mfb_src_rdy),
        .tx_mfb_dst_rdy (tx_mfb_dst_rdy)
    );

    // Region r occupies slot r of the flat metadata bus
    for (genvar r = 0; r < MFB_REGIONS; r++) begin : g_meta_flat
        assign tx_mfb_meta[r*MFB_SLOT_WIDTH +: MFB_SLOT_WIDTH] = tx_slot[r].flat;
    end

endmodule

//--- hdl/mfb_pkg.sv
/*
 * MFB frame bus geometry
 * Region sizes and the per-region output metadata slot
 */

package mfb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus geometry
    localparam int MFB_REGIONS      = 2;
    localparam int MFB_REGION_WIDTH = 32;  // Data bits per region
    localparam int MFB_META_WIDTH   = 8;   // Frame metadata per region

    // Frame metadata followed by the inserted item
    localparam int MFB_SLOT_WIDTH = MFB_META_WIDTH + mvb_pkg::MVB_ITEM_WIDTH;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output metadata slot of one region
    //
    // The flat view is what leaves on tx_mfb_meta, the field view is how the
    // merge stage fills it. Frame metadata sits above the item.
    typedef union packed {
        logic [MFB_SLOT_WIDTH-1:0] flat;
        struct packed {
            logic [MFB_META_WIDTH-1:0]          meta;
            logic [mvb_pkg::MVB_ITEM_WIDTH-1:0] item;
        } fields;
    } meta_slot_u;

endpackage

//--- hdl/mfb_sof_scan.sv
/*
 * MFB SOF scanner
 * One-entry register stage that counts frame starts per word
 */

module mfb_sof_scan (
    input  logic                                                      clk,
    input  logic                                                      rst_n,

    input  logic [mfb_pkg::MFB_REGIONS*mfb_pkg::MFB_REGION_WIDTH-1:0] rx_mfb_data,
    input  logic [mfb_pkg::MFB_REGIONS*mfb_pkg::MFB_META_WIDTH-1:0]   rx_mfb_meta,
    input  logic [mfb_pkg::MFB_REGIONS-1:0]                           rx_mfb_sof,
    input  logic [mfb_pkg::MFB_REGIONS-1:0]                           rx_mfb_eof,
    input  logic                                                      rx_mfb_src_rdy,
    output logic                                                      rx_mfb_dst_rdy,

    output logic [mfb_pkg::MFB_REGIONS*mfb_pkg::MFB_REGION_WIDTH-1:0] scan_data,
    output logic [mfb_pkg::MFB_REGIONS*mfb_pkg::MFB_META_WIDTH-1:0]   scan_meta,
    output logic [mfb_pkg::MFB_REGIONS-1:0]                           scan_sof,
    output logic [mfb_pkg::MFB_REGIONS-1:0]                           scan_eof,
    output logic [1:0]                                                scan_sof_cnt,
    output logic [mfb_pkg::MFB_REGIONS-1:0]                           scan_item_idx,
    output logic                                                      scan_vld,
    input  logic                                                      scan_take
);
    import mfb_pkg::*;

    logic                   accept;
    logic [1:0]             sof_cnt;
    logic [MFB_REGIONS-1:0] item_idx;

    assign rx_mfb_dst_rdy = !scan_vld || scan_take;  // Empty or draining
    assign accept         = rx_mfb_src_rdy && rx_mfb_dst_rdy;

    // Running SOF index, lower region gets the older item
    always_comb begin
        sof_cnt = '0;
        for (int r = 0; r < MFB_REGIONS; r++) begin
            item_idx[r] = sof_cnt[0];
            if (rx_mfb_sof[r]) begin
                sof_cnt = sof_cnt + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_vld <= 1'b0;
        end else if (accept) begin
            scan_vld <= 1'b1;
        end else if (scan_take) begin
            scan_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            scan_data     <= rx_mfb_data;
            scan_meta     <= rx_mfb_meta;
            scan_sof      <= rx_mfb_sof;
            scan_eof      <= rx_mfb_eof;
            scan_sof_cnt  <= sof_cnt;
            scan_item_idx <= item_idx;
        end
    end

    // Word waits untouched until merge takes it
    a_scan_hold: assert property (@(posedge clk) disable iff (!rst_n)
        scan_vld && !scan_take |=> scan_vld && $stable(scan_data) && $stable(scan_meta)
            && $stable(scan_sof) && $stable(scan_eof) && $stable(scan_sof_cnt)
            && $stable(scan_item_idx)
    ) else $error("Scanned MFB word changed before it was taken");

endmodule

//--- hdl/mvb_item_queue.sv
/*
 * MVB item queue
 * Compacts the valid items of each MVB word into a circular FIFO
 * and presents the two oldest entries to the merge stage
 */

module mvb_item_queue (
    input  logic                                                  clk,
    input  logic                                                  rst_n,

    input  logic [mvb_pkg::MVB_ITEMS*mvb_pkg::MVB_ITEM_WIDTH-1:0] rx_mvb_data,
    input  logic [mvb_pkg::MVB_ITEMS-1:0]                         rx_mvb_vld,
    input  logic                                                  rx_mvb_src_rdy,
    output logic                                                  rx_mvb_dst_rdy,

    output logic [mvb_pkg::MVB_ITEM_WIDTH-1:0]                    item_head0,
    output logic [mvb_pkg::MVB_ITEM_WIDTH-1:0]                    item_head1,
    output logic [mvb_pkg::MVB_CNT_WIDTH-1:0]                     item_cnt,
    input  logic [1:0]                                            pop_cnt
);
    import mvb_pkg::*;

    logic [MVB_ITEM_WIDTH-1:0] mem [MVB_FIFO_DEPTH];

    logic [MVB_CNT_WIDTH-2:0]  wr_ptr;
    logic [MVB_CNT_WIDTH-2:0]  rd_ptr;
    logic [MVB_CNT_WIDTH-2:0]  rd_ptr_nxt;
    logic [MVB_CNT_WIDTH-1:0]  cnt;

    logic                      push;
    logic [MVB_CNT_WIDTH-1:0]  push_cnt;
    logic [MVB_CNT_WIDTH-1:0]  pop_ext;
    logic [MVB_CNT_WIDTH-2:0]  wr_addr [MVB_ITEMS];
    logic [MVB_ITEMS-1:0]      wr_en;

    // Room for a whole word of items
    assign rx_mvb_dst_rdy = cnt <= MVB_CNT_WIDTH'(MVB_FIFO_DEPTH - MVB_ITEMS);
    assign push           = rx_mvb_src_rdy && rx_mvb_dst_rdy;
    assign pop_ext        = MVB_CNT_WIDTH'(pop_cnt);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Slot compaction
    //
    // Each valid slot lands behind the valid slots below it, so items keep
    // their arrival order and empty slots leave no holes.
    always_comb begin : compact
        logic [MVB_CNT_WIDTH-1:0] ofs;

        ofs = '0;
        for (int j = 0; j < MVB_ITEMS; j++) begin
            wr_addr[j] = wr_ptr + ofs[MVB_CNT_WIDTH-2:0];
            wr_en[j]   = push && rx_mvb_vld[j];
            if (rx_mvb_vld[j]) begin
                ofs = ofs + MVB_CNT_WIDTH'(1);
            end
        end
        push_cnt = push ? ofs : '0;  // Empty words are accepted and dropped
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < MVB_ITEMS; j++) begin
            if (wr_en[j]) begin
                mem[wr_addr[j]] <= rx_mvb_data[j*MVB_ITEM_WIDTH +: MVB_ITEM_WIDTH];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            wr_ptr <= wr_ptr + push_cnt[MVB_CNT_WIDTH-2:0];
            rd_ptr <= rd_ptr + pop_ext[MVB_CNT_WIDTH-2:0];
            cnt    <= cnt + push_cnt - pop_ext;  // Push and pop may overlap
        end
    end

    assign rd_ptr_nxt = rd_ptr + (MVB_CNT_WIDTH-1)'(1);
    assign item_head0 = mem[rd_ptr];
    assign item_head1 = mem[rd_ptr_nxt];  // Valid only when cnt is 2 or more
    assign item_cnt   = cnt;

    // Merge stage pops only what it has seen
    a_pop_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        pop_ext <= cnt
    ) else $error("Item queue popped %0d with %0d stored", pop_cnt, cnt);

    // Without dst_rdy no item may enter, so occupancy cannot grow
    a_no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        !rx_mvb_dst_rdy |=> cnt <= $past(cnt)
    ) else $error("Item queue grew while rx_mvb_dst_rdy was low");

endmodule

//--- hdl/mvb_pkg.sv
/*
 * MVB item bus geometry
 * Slot count, item width and item queue sizing
 */

package mvb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus geometry
    localparam int MVB_ITEMS      = 2;   // Item slots per word
    localparam int MVB_ITEM_WIDTH = 16;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Item queue
    localparam int MVB_FIFO_DEPTH = 8;   // Power of two, pointers wrap
    localparam int MVB_CNT_WIDTH  = 4;   // Holds 0 up to full depth

endpackage

//--- metadata_insertor.f
hdl/mvb_pkg.sv
hdl/mfb_pkg.sv
hdl/mvb_item_queue.sv
hdl/mfb_sof_scan.sv
hdl/meta_merge.sv
hdl/metadata_insertor.sv
verif/metadata_insertor_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the metadata insertor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=metadata_insertor_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module metadata_insertor_tb \
    -f metadata_insertor.f \
    --Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    exit 1
fi
exit 0

//--- verif/metadata_insertor_tb.sv
/*
 * Testbench for the frame metadata insertor
 * Feeds MVB items and MFB frames, checks every TX word against a reference model
 */

module metadata_insertor_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import mvb_pkg::*;
    import mfb_pkg::*;

    localparam int DATA_W         = MFB_REGIONS * MFB_REGION_WIDTH;
    localparam int META_W         = MFB_REGIONS * MFB_META_WIDTH;
    localparam int TXMETA_W       = MFB_REGIONS * MFB_SLOT_WIDTH;
    localparam int RAND_FRAMES    = 40;
    localparam int TOTAL_WORDS    = 10 + 3 * RAND_FRAMES;  // Directed plus random words
    localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 40 + 200;

    logic                                clk;
    logic                                rst_n;
    logic [MVB_ITEMS*MVB_ITEM_WIDTH-1:0] rx_mvb_data;
    logic [MVB_ITEMS-1:0]                rx_mvb_vld;
    logic                                rx_mvb_src_rdy;
    logic                                rx_mvb_dst_rdy;
    logic [DATA_W-1:0]                   rx_mfb_data;
    logic [META_W-1:0]                   rx_mfb_meta;
    logic [MFB_REGIONS-1:0]              rx_mfb_sof;
    logic [MFB_REGIONS-1:0]              rx_mfb_eof;
    logic                                rx_mfb_src_rdy;
    logic                                rx_mfb_dst_rdy;
    logic [DATA_W-1:0]                   tx_mfb_data;
    logic [TXMETA_W-1:0]                 tx_mfb_meta;
    logic [MFB_REGIONS-1:0]              tx_mfb_sof;
    logic [MFB_REGIONS-1:0]              tx_mfb_eof;
    logic                                tx_mfb_src_rdy;
    logic                                tx_mfb_dst_rdy;

    logic [31:0]               rng_state = 32'h5229;
    logic                      bp_en = 1'b0;    // Random back-pressure on TX
    int                        err_cnt = 0;
    int                        check_cnt = 0;
    int                        test_err_base = 0;
    int                        mfb_in_cnt = 0;
    int                        mfb_out_cnt = 0;

    // Reference model state
    logic [MVB_ITEM_WIDTH-1:0] item_q[$];
    logic [DATA_W-1:0]         word_data_q[$];
    logic [META_W-1:0]         word_meta_q[$];
    logic [MFB_REGIONS-1:0]    word_sof_q[$];
    logic [MFB_REGIONS-1:0]    word_eof_q[$];

    logic                      held = 1'b0;
    logic [DATA_W-1:0]         held_data;
    logic [TXMETA_W-1:0]       held_meta;
    logic [MFB_REGIONS-1:0]    held_sof;
    logic [MFB_REGIONS-1:0]    held_eof;

    metadata_insertor dut_i (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state ^ (rng_state >> 15);  // Fold high bits into the weak low ones
    endfunction

    // Frame metadata above the item, one slot per region, item only at an SOF
    function automatic logic [TXMETA_W-1:0] expected_meta(input logic [META_W-1:0] meta,
                                                          input logic [MFB_REGIONS-1:0] sof);
        logic [TXMETA_W-1:0]       res;
        logic [MVB_ITEM_WIDTH-1:0] item;
        res = '0;
        for (int r = 0; r < MFB_REGIONS; r++) begin
            item = '0;
            if (sof[r]) begin
                item = item_q.pop_front();  // Oldest item, lower region first
            end
            res[r*MFB_SLOT_WIDTH +: MFB_SLOT_WIDTH] = {meta[r*MFB_META_WIDTH +: MFB_META_WIDTH], item};
        end
        return res;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        check_cnt++;
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("Error: %s", msg);
        err_cnt++;
    endtask

    task automatic finish_test(input int num, input string name);
        $display("Test %0d %s finished with %0d errors", num, name, err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus drivers, entered 2 ns after a rising edge
    task automatic send_mvb(input logic [MVB_ITEMS*MVB_ITEM_WIDTH-1:0] data,
                            input logic [MVB_ITEMS-1:0] vld);
        logic done;
        rx_mvb_data    = data;
        rx_mvb_vld     = vld;
        rx_mvb_src_rdy = 1'b1;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = rx_mvb_dst_rdy;
            @(posedge clk);
            #2;
        end
        rx_mvb_src_rdy = 1'b0;
    endtask

    task automatic send_mfb(input logic [DATA_W-1:0] data, input logic [META_W-1:0] meta,
                            input logic [MFB_REGIONS-1:0] sof, input logic [MFB_REGIONS-1:0] eof);
        logic done;
        rx_mfb_data    = data;
        rx_mfb_meta    = meta;
        rx_mfb_sof     = sof;
        rx_mfb_eof     = eof;
        rx_mfb_src_rdy = 1'b1;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = rx_mfb_dst_rdy;
            @(posedge clk);
            #2;
        end
        rx_mfb_src_rdy = 1'b0;
    endtask

    task automatic wait_drained();
        do begin
            @(posedge clk);
        end while (mfb_out_cnt != mfb_in_cnt);
        #2;
    endtask

    always @(posedge clk) begin
        #2;
        if (bp_en) begin
            tx_mfb_dst_rdy = (lcg_rand() % 3) != 0;
        end else begin
            tx_mfb_dst_rdy = 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Input logging and TX comparison, both at the falling edge
    always @(negedge clk) begin : log_inputs
        if (rst_n && rx_mvb_src_rdy && rx_mvb_dst_rdy) begin
            for (int j = 0; j < MVB_ITEMS; j++) begin
                if (rx_mvb_vld[j]) begin
                    item_q.push_back(rx_mvb_data[j*MVB_ITEM_WIDTH +: MVB_ITEM_WIDTH]);
                end
            end
        end
        if (rst_n && rx_mfb_src_rdy && rx_mfb_dst_rdy) begin
            word_data_q.push_back(rx_mfb_data);
            word_meta_q.push_back(rx_mfb_meta);
            word_sof_q.push_back(rx_mfb_sof);
            word_eof_q.push_back(rx_mfb_eof);
            mfb_in_cnt++;
        end
    end

    always @(negedge clk) begin : compare
        logic [TXMETA_W-1:0] exp_meta;
        if (rst_n && tx_mfb_src_rdy) begin
            if (held) begin
                check_value("tx_mfb_data (stalled)", tx_mfb_data, held_data);
                check_value("tx_mfb_meta (stalled)", tx_mfb_meta, held_meta);
                check_value("tx_mfb_sof (stalled)", tx_mfb_sof, held_sof);
                check_value("tx_mfb_eof (stalled)", tx_mfb_eof, held_eof);
            end
            held      = !tx_mfb_dst_rdy;
            held_data = tx_mfb_data;
            held_meta = tx_mfb_meta;
            held_sof  = tx_mfb_sof;
            held_eof  = tx_mfb_eof;
            if (tx_mfb_dst_rdy && word_data_q.size() == 0) begin
                report_failure("TX sent a word that never entered on the MFB input");
            end else if (tx_mfb_dst_rdy) begin
                if (item_q.size() < $countones(word_sof_q[0])) begin
                    report_failure("TX frame start carries an item that never arrived on MVB");
                end else begin
                    exp_meta = expected_meta(word_meta_q[0], word_sof_q[0]);
                    check_value("tx_mfb_data", tx_mfb_data, word_data_q[0]);
                    check_value("tx_mfb_meta", tx_mfb_meta, exp_meta);
                    check_value("tx_mfb_sof", tx_mfb_sof, word_sof_q[0]);
                    check_value("tx_mfb_eof", tx_mfb_eof, word_eof_q[0]);
                end
                void'(word_data_q.pop_front());
                void'(word_meta_q.pop_front());
                void'(word_sof_q.pop_front());
                void'(word_eof_q.pop_front());
                mfb_out_cnt++;
            end
        end else if (rst_n && held) begin
            report_failure("tx_mfb_src_rdy fell while the TX word was stalled");
            held = 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Random mix of frames and items, item total matches the frame starts
    task automatic run_random_mix();
        logic [DATA_W-1:0]                   f_data[$];
        logic [31:0]                         f_ctl[$];
        logic [MVB_ITEMS*MVB_ITEM_WIDTH-1:0] m_data[$];
        logic [MVB_ITEMS-1:0]                m_vld[$];
        logic [31:0]                         r;
        logic [MVB_ITEMS-1:0]                vld;
        int                                  need;
        need = 0;
        for (int i = 0; i < RAND_FRAMES; i++) begin
            f_data.push_back({lcg_rand(), lcg_rand()});
            r = lcg_rand();
            f_ctl.push_back(r);  // Meta, SOF and EOF in the low 20 bits
            need += $countones(r[17:16]);
        end
        while (need > 0) begin
            vld = lcg_rand() >> 7;
            if (need == 1 && vld == 2'b11) begin
                vld = 2'b10;
            end
            m_data.push_back(lcg_rand());
            m_vld.push_back(vld);
            need -= $countones(vld);
        end
        bp_en = 1'b1;
        fork
            foreach (f_data[i]) begin
                if (lcg_rand() % 4 == 0) begin
                    @(posedge clk);
                    #2;
                end
                send_mfb(f_data[i], f_ctl[i][15:0], f_ctl[i][17:16], f_ctl[i][19:18]);
            end
            foreach (m_data[i]) begin
                if (lcg_rand() % 3 == 0) begin
                    @(posedge clk);
                    #2;
                end
                send_mvb(m_data[i], m_vld[i]);
            end
        join
        wait_drained();
        bp_en = 1'b0;
    endtask

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial begin : main
        clk            = 1'b0;
        rst_n          = 1'b0;
        rx_mvb_data    = '0;
        rx_mvb_vld     = '0;
        rx_mvb_src_rdy = 1'b0;
        rx_mfb_data    = '0;
        rx_mfb_meta    = '0;
        rx_mfb_sof     = '0;
        rx_mfb_eof     = '0;
        rx_mfb_src_rdy = 1'b0;
        tx_mfb_dst_rdy = 1'b1;
        repeat (16) @(posedge clk);
        #2 rst_n = 1'b1;

        @(negedge clk);
        check_value("tx_mfb_src_rdy", tx_mfb_src_rdy, 1'b0);
        check_value("rx_mfb_dst_rdy", rx_mfb_dst_rdy, 1'b1);
        check_value("rx_mvb_dst_rdy", rx_mvb_dst_rdy, 1'b1);
        finish_test(1, "reset state");
        @(posedge clk);
        #2;

        send_mvb({16'hdead, 16'h1234}, 2'b01);  // Slot 1 ignored
        send_mfb({32'h0bad_f00d, 32'h1111_2222}, {8'h5a, 8'h3c}, 2'b01, 2'b01);
        wait_drained();
        finish_test(2, "single frame in region 0");

        send_mvb({16'h2222, 16'hffff}, 2'b10);
        send_mvb({16'heeee, 16'hdddd}, 2'b00);  // Empty word is dropped
        send_mvb({16'hcccc, 16'h3333}, 2'b01);
        send_mfb({32'h89ab_cdef, 32'h0123_4567}, {8'hc1, 8'h7e}, 2'b11, 2'b01);
        wait_drained();
        finish_test(3, "two frame starts in one word");

        fork
            begin
                send_mfb({32'haaaa_0001, 32'h5555_0001}, {8'h11, 8'h22}, 2'b01, 2'b00);
                send_mfb({32'haaaa_0002, 32'h5555_0002}, {8'h33, 8'h44}, 2'b11, 2'b10);
            end
            begin
                repeat (8) begin
                    @(negedge clk);
                    check_value("tx_mfb_src_rdy", tx_mfb_src_rdy, 1'b0);
                end
                check_value("rx_mfb_dst_rdy", rx_mfb_dst_rdy, 1'b0);
                @(posedge clk);
                #2;
                send_mvb({16'h4b02, 16'h4b01}, 2'b11);
                send_mvb({16'h0000, 16'h4b03}, 2'b01);
            end
        join
        wait_drained();
        finish_test(4, "frames waiting for items");

        run_random_mix();
        finish_test(5, "random mix under back-pressure");

        if (item_q.size() != 0) begin
            report_failure("items were accepted that no frame start consumed");
        end
        $display("Summary: 5 tests, %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
